// ==== Makefile ====
TOP = tb_sdhc_dma

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sources.f -o sim

run: build
	obj_dir/sim | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== sources.f ====
src/sdhc_reg_pkg.sv
src/adma_pkg.sv
src/host_registers.sv
src/adma_engine.sv
src/ram_arbiter.sv
src/system_ram.sv
src/data_buffer.sv
src/sdhc_dma_top.sv
testbench/clock_gen.sv
testbench/tb_sdhc_dma.sv

// ==== src/adma_engine.sv ====
`timescale 1ns/1ps

module adma_engine
   import sdhc_reg_pkg::*;
   import adma_pkg::*;
#(
   parameter int ADDR_WIDTH = 10
) (
   input  logic           CLK,
   input  logic           reset,
   input  logic           start,
   input  logic [31:0]    table_addr,
   input  transfer_mode_t mode,
   output mem_req_t       mem_req,
   input  logic           mem_grant,
   input  logic           mem_rvalid,
   input  logic [31:0]    mem_rdata,
   output logic           tx_write,
   output logic [31:0]    tx_data,
   input  logic           tx_full,
   output logic           rx_read,
   input  logic [31:0]    rx_data,
   input  logic           rx_empty,
   output logic           busy,
   output logic           done,
   output adma_error_t    error_code
);

   typedef enum logic [3:0] {
      st_idle, st_fetch, st_fetch_wait, st_decode, st_next,
      st_tx_read, st_tx_wait, st_tx_push,
      st_rx_pop, st_rx_wait, st_rx_write
   } state_t;

   state_t            state;
   adma_desc_u        desc;
   adma_desc_fields_t fields;
   logic              word_sel;    // which descriptor word is fetched
   logic [31:0]       desc_ptr;
   logic [31:0]       xfer_addr;
   logic [15:0]       count;       // words left in current tran
   logic [31:0]       rx_word;
   logic [32:0]       span_end;
   logic              past_end;

   assign fields   = desc.fields;
   assign span_end = {1'b0, fields.address} + {17'd0, fields.length};
   assign past_end = span_end > (33'd1 << ADDR_WIDTH);

   //////////////////////////////
   // bus requests
   //////////////////////////////
   always_comb begin
      mem_req = '0;
      case (state)
         st_fetch: begin
            mem_req.valid = 1'b1;
            mem_req.addr  = desc_ptr + {31'd0, word_sel};
         end
         st_tx_read: begin
            mem_req.valid = 1'b1;
            mem_req.addr  = xfer_addr;
         end
         st_rx_write: begin
            mem_req.valid = 1'b1;
            mem_req.write = 1'b1;
            mem_req.addr  = xfer_addr;
            mem_req.wdata = rx_word;
         end
         default: ;
      endcase
   end

   assign tx_write = (state == st_tx_push) && !tx_full;
   assign rx_read  = (state == st_rx_pop) && !rx_empty;

   //////////////////////////////
   // state machine
   //////////////////////////////
   always_ff @(posedge CLK) begin
      if (reset) begin
         state      <= st_idle;
         word_sel   <= 1'b0;
         busy       <= 1'b0;
         done       <= 1'b0;
         error_code <= err_none;
      end else begin
         done <= 1'b0;
         case (state)
            st_idle: if (start) begin
               desc_ptr   <= table_addr;
               word_sel   <= 1'b0;
               error_code <= err_none;
               busy       <= 1'b1;
               state      <= st_fetch;
            end
            st_fetch: if (mem_grant) state <= st_fetch_wait;
            st_fetch_wait: if (mem_rvalid) begin
               desc.words[word_sel] <= mem_rdata;
               word_sel <= ~word_sel;
               state    <= word_sel ? st_decode : st_fetch;
            end
            st_decode: begin
               xfer_addr <= fields.address;
               count     <= fields.length;
               if (!fields.valid) begin
                  error_code <= err_invalid_desc;
                  done       <= 1'b1;
                  busy       <= 1'b0;
                  state      <= st_idle;
               end else if (fields.act == act_tran) begin
                  if (past_end) begin
                     error_code <= err_bad_length;  // nothing moved
                     done       <= 1'b1;
                     busy       <= 1'b0;
                     state      <= st_idle;
                  end else if (fields.length == 16'd0)
                     state <= st_next;
                  else if (mode.direction)
                     state <= st_rx_pop;
                  else
                     state <= st_tx_read;
               end else
                  state <= st_next;  // nop, link
            end
            st_next: begin
               if (fields.end_bit) begin
                  done  <= 1'b1;
                  busy  <= 1'b0;
                  state <= st_idle;
               end else begin
                  desc_ptr <= (fields.act == act_link) ? fields.address : desc_ptr + 32'd2;
                  state    <= st_fetch;
               end
            end
            st_tx_read: if (mem_grant) state <= st_tx_wait;
            st_tx_wait: if (mem_rvalid) begin
               tx_data <= mem_rdata;
               state   <= st_tx_push;
            end
            st_tx_push: if (!tx_full) begin
               xfer_addr <= xfer_addr + 32'd1;
               count     <= count - 16'd1;
               state     <= (count == 16'd1) ? st_next : st_tx_read;
            end
            st_rx_pop: if (!rx_empty) state <= st_rx_wait;
            st_rx_wait: begin
               rx_word <= rx_data;  // buffer dout valid now
               state   <= st_rx_write;
            end
            st_rx_write: if (mem_grant) begin
               xfer_addr <= xfer_addr + 32'd1;
               count     <= count - 16'd1;
               state     <= (count == 16'd1) ? st_next : st_rx_pop;
            end
            default: state <= st_idle;
         endcase
      end
   end

endmodule

// ==== src/adma_pkg.sv ====
package adma_pkg;

   //////////////////////////////
   // ADMA2 descriptor
   //////////////////////////////
   typedef enum logic [1:0] {
      act_nop  = 2'b00,
      act_tran = 2'b10,
      act_link = 2'b11   // 2'b01 reserved, handled as nop
   } adma_act_t;

   // field view, msb first, 64 bits total
   typedef struct packed {
      logic [31:0] address;   // word address in system ram
      logic [15:0] length;    // counted in 32-bit words
      logic [9:0]  rsvd_hi;
      adma_act_t   act;       // bits 5:4
      logic        rsvd_lo;
      logic        int_bit;
      logic        end_bit;
      logic        valid;     // bit 0
   } adma_desc_fields_t;

   // the engine fills words[0] first, then words[1]
   typedef union packed {
      adma_desc_fields_t fields;
      logic [1:0][31:0]  words;
   } adma_desc_u;

   //////////////////////////////
   // memory bus
   //////////////////////////////
   typedef struct packed {
      logic        valid;
      logic        write;
      logic [31:0] addr;   // word address
      logic [31:0] wdata;
   } mem_req_t;

endpackage

// ==== src/data_buffer.sv ====
`timescale 1ns/1ps

module data_buffer #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic        CLK,
   input  logic        reset,
   input  logic        write,
   input  logic [31:0] din,
   input  logic        read,
   output logic [31:0] dout,
   output logic        full,
   output logic        empty
);

   localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

   logic [31:0]        mem [FIFO_DEPTH];
   logic [PTR_WIDTH:0] wr_ptr;  // msb is the wrap bit
   logic [PTR_WIDTH:0] rd_ptr;
   logic               do_write;
   logic               do_read;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[PTR_WIDTH] != rd_ptr[PTR_WIDTH]) &&
                  (wr_ptr[PTR_WIDTH-1:0] == rd_ptr[PTR_WIDTH-1:0]);

   assign do_write = write && !full;
   assign do_read  = read && !empty;

   always_ff @(posedge CLK) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_write)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_read)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge CLK) begin
      if (do_write)
         mem[wr_ptr[PTR_WIDTH-1:0]] <= din;
      if (do_read)
         dout <= mem[rd_ptr[PTR_WIDTH-1:0]];  // valid the cycle after read
   end

endmodule

// ==== src/host_registers.sv ====
`timescale 1ns/1ps

module host_registers import sdhc_reg_pkg::*; (
   input  logic           CLK,
   input  logic           reset,
   input  logic           reg_write,
   input  reg_offset_t    reg_sel,
   input  logic [15:0]    reg_wdata,
   input  logic           busy,
   input  logic           done,
   input  adma_error_t    error_code,
   output logic           start,
   output logic [31:0]    table_addr,
   output transfer_mode_t mode,
   output adma_error_t    adma_error
);

   logic [15:0] addr_lo;
   logic [15:0] addr_hi;

   always_ff @(posedge CLK) begin
      if (reset) begin
         addr_lo    <= '0;
         addr_hi    <= '0;
         mode       <= '0;
         adma_error <= err_none;
      end else begin
         if (reg_write) begin
            case (reg_sel)
               sel_adma_addr_lo: addr_lo <= reg_wdata;
               sel_adma_addr_hi: addr_hi <= reg_wdata;
               sel_transfer_mode: begin
                  mode.direction  <= reg_wdata[mode_direction_bit];
                  mode.dma_enable <= reg_wdata[mode_dma_enable_bit];
               end
               default: ;  // command only triggers start
            endcase
         end
         if (done)
            adma_error <= error_code;  // status of the last transfer
      end
   end

   assign table_addr = {addr_hi, addr_lo};

   // one cycle pulse, a start while busy is dropped
   assign start = reg_write && (reg_sel == sel_command) &&
                  reg_wdata[cmd_start_bit] && !busy;

endmodule

// ==== src/ram_arbiter.sv ====
`timescale 1ns/1ps

module ram_arbiter import adma_pkg::*; #(
   parameter int ADDR_WIDTH = 10
) (
   input  logic                  CLK,
   input  logic                  reset,
   input  mem_req_t              dma_req,
   input  mem_req_t              host_req,
   output logic                  dma_grant,
   output logic                  host_grant,
   output logic                  dma_rvalid,
   output logic                  host_rvalid,
   output logic [ADDR_WIDTH-1:0] ram_addr,
   output logic                  ram_write,
   output logic [31:0]           ram_wdata
);

   logic     last_host;  // host won the last grant
   mem_req_t winner;

   // dma wins unless host waits and dma had the last turn
   assign dma_grant  = dma_req.valid && (!host_req.valid || last_host);
   assign host_grant = host_req.valid && !dma_grant;

   assign winner    = host_grant ? host_req : dma_req;
   assign ram_addr  = winner.addr[ADDR_WIDTH-1:0];
   assign ram_write = winner.valid && winner.write;  // valid only when granted
   assign ram_wdata = winner.wdata;

   always_ff @(posedge CLK) begin
      if (reset) begin
         last_host   <= 1'b0;
         dma_rvalid  <= 1'b0;
         host_rvalid <= 1'b0;
      end else begin
         if (dma_grant || host_grant)
            last_host <= host_grant;
         dma_rvalid  <= dma_grant && !dma_req.write;    // steers ram_rdata
         host_rvalid <= host_grant && !host_req.write;
      end
   end

endmodule

// ==== src/sdhc_dma_top.sv ====
`timescale 1ns/1ps

module sdhc_dma_top
   import sdhc_reg_pkg::*;
   import adma_pkg::*;
#(
   parameter int ADDR_WIDTH = 10,
   parameter int FIFO_DEPTH = 16
) (
   input  logic        CLK,
   input  logic        reset,
   input  logic        reg_write,
   input  reg_offset_t reg_sel,
   input  logic [15:0] reg_wdata,
   input  mem_req_t    host_req,
   output logic        host_grant,
   output logic        host_rvalid,
   output logic [31:0] host_rdata,
   input  logic        dat_read,
   output logic [31:0] dat_dout,
   output logic        dat_empty,
   input  logic        dat_write,
   input  logic [31:0] dat_din,
   output logic        dat_full,
   output logic        busy,
   output logic        done,
   output adma_error_t adma_error
);

   logic                  start;
   logic [31:0]           table_addr;
   transfer_mode_t        mode;
   adma_error_t           error_code;
   mem_req_t              dma_req;
   logic                  dma_grant;
   logic                  dma_rvalid;
   logic [ADDR_WIDTH-1:0] ram_addr;
   logic                  ram_write;
   logic [31:0]           ram_wdata;
   logic [31:0]           ram_rdata;
   logic                  tx_write;
   logic [31:0]           tx_data;
   logic                  tx_full;
   logic                  rx_read;
   logic [31:0]           rx_data;
   logic                  rx_empty;

   assign host_rdata = ram_rdata;  // shared read bus, qualified by host_rvalid

   host_registers host_registers (
      .CLK(CLK), .reset(reset),
      .reg_write(reg_write), .reg_sel(reg_sel), .reg_wdata(reg_wdata),
      .busy(busy), .done(done), .error_code(error_code),
      .start(start), .table_addr(table_addr), .mode(mode), .adma_error(adma_error)
   );

   adma_engine #(.ADDR_WIDTH(ADDR_WIDTH)) adma_engine (
      .CLK(CLK), .reset(reset),
      .start(start), .table_addr(table_addr), .mode(mode),
      .mem_req(dma_req), .mem_grant(dma_grant), .mem_rvalid(dma_rvalid),
      .mem_rdata(ram_rdata),
      .tx_write(tx_write), .tx_data(tx_data), .tx_full(tx_full),
      .rx_read(rx_read), .rx_data(rx_data), .rx_empty(rx_empty),
      .busy(busy), .done(done), .error_code(error_code)
   );

   //////////////////////////////
   // system memory
   //////////////////////////////
   ram_arbiter #(.ADDR_WIDTH(ADDR_WIDTH)) ram_arbiter (
      .CLK(CLK), .reset(reset),
      .dma_req(dma_req), .host_req(host_req),
      .dma_grant(dma_grant), .host_grant(host_grant),
      .dma_rvalid(dma_rvalid), .host_rvalid(host_rvalid),
      .ram_addr(ram_addr), .ram_write(ram_write), .ram_wdata(ram_wdata)
   );

   system_ram #(.ADDR_WIDTH(ADDR_WIDTH)) system_ram (
      .CLK(CLK),
      .ram_addr(ram_addr), .ram_write(ram_write),
      .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
   );

   //////////////////////////////
   // data buffers
   //////////////////////////////
   data_buffer #(.FIFO_DEPTH(FIFO_DEPTH)) tx_buffer (  // dma writes, dat reads
      .CLK(CLK), .reset(reset),
      .write(tx_write), .din(tx_data),
      .read(dat_read), .dout(dat_dout),
      .full(tx_full), .empty(dat_empty)
   );

   data_buffer #(.FIFO_DEPTH(FIFO_DEPTH)) rx_buffer (  // dat writes, dma reads
      .CLK(CLK), .reset(reset),
      .write(dat_write), .din(dat_din),
      .read(rx_read), .dout(rx_data),
      .full(dat_full), .empty(rx_empty)
   );

endmodule

// ==== src/sdhc_reg_pkg.sv ====
package sdhc_reg_pkg;

   //////////////////////////////
   // host register select
   //////////////////////////////
   typedef enum logic [3:0] {
      sel_adma_addr_lo  = 4'h0,  // table address bits 15:0
      sel_adma_addr_hi  = 4'h1,  // table address bits 31:16
      sel_transfer_mode = 4'h2,
      sel_command       = 4'h3
   } reg_offset_t;

   // bit positions inside the written halfword
   localparam int cmd_start_bit       = 0;
   localparam int mode_dma_enable_bit = 0;
   localparam int mode_direction_bit  = 4;  // same place as the SD transfer mode reg

   typedef struct packed {
      logic direction;   // 1 = read, card to ram
      logic dma_enable;
   } transfer_mode_t;

   typedef enum logic [1:0] {
      err_none         = 2'd0,
      err_invalid_desc = 2'd1,
      err_bad_length   = 2'd2  // tran runs past end of ram
   } adma_error_t;

endpackage

// ==== src/system_ram.sv ====
`timescale 1ns/1ps

module system_ram #(
   parameter int ADDR_WIDTH = 10
) (
   input  logic                  CLK,
   input  logic [ADDR_WIDTH-1:0] ram_addr,
   input  logic                  ram_write,
   input  logic [31:0]           ram_wdata,
   output logic [31:0]           ram_rdata
);

   localparam int DEPTH = 1 << ADDR_WIDTH;

   logic [31:0] mem [DEPTH];

   always_ff @(posedge CLK) begin
      if (ram_write)
         mem[ram_addr] <= ram_wdata;
      ram_rdata <= mem[ram_addr];  // one cycle read latency
   end

endmodule

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
   parameter int RESET_CYCLES = 16
) (
   output logic CLK,
   output logic reset
);

   initial begin
      CLK = 1'b0;
      forever #2 CLK = ~CLK;  // 4 ns period
   end

   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge CLK);
      reset <= 1'b0;
   end

endmodule

// ==== testbench/sdhc_dma_testdata.txt ====
# records, all fields hex. F base count key: host writes ram[a] = key + a * 00010003
# W addr data: one host write. E base count key: expected words by the same rule, in order
# G table dir stall_pct err bg_base bg_count: start, run DAT side and host reads, check
# write, one tran with end
F 100 8 a5a50000
W 000 00080023
W 001 00000100
E 100 8 a5a50000
G 000 0 0 0 0 0
# tran, nop, link to 040, tran with end, host reads 300 meanwhile
F 300 6 77000000
F 120 4 12340000
F 140 5 56780000
W 010 00040021
W 011 00000120
W 012 00000001
W 013 00000000
W 014 00000031
W 015 00000040
W 040 00050023
W 041 00000140
E 120 4 12340000
E 140 5 56780000
G 010 0 20 0 300 6
# read into 200
W 020 00060023
W 021 00000200
E 200 6 3c3c0000
G 020 1 0 0 0 0
# back-pressure both ways
F 160 18 9a9a0000
W 030 00180023
W 031 00000160
E 160 18 9a9a0000
G 030 0 55 0 0 0
W 034 00140023
W 035 00000220
E 220 14 c3c30000
G 034 1 55 0 300 6
# valid clear, then tran past end of ram
W 038 00000020
W 039 00000000
G 038 0 0 1 0 0
W 03c 00100023
W 03d 000003f8
G 03c 0 0 2 0 0

// ==== testbench/tb_sdhc_dma.sv ====
`timescale 1ns/1ps

module tb_sdhc_dma
   import sdhc_reg_pkg::*;
   import adma_pkg::*;
();

   localparam int ADDR_WIDTH = 10;
   localparam int RAM_WORDS  = 1 << ADDR_WIDTH;
   localparam int TIMEOUT    = 5000;  // cycles per wait loop

   logic        CLK;
   logic        reset;
   logic        reg_write;
   reg_offset_t reg_sel;
   logic [15:0] reg_wdata;
   mem_req_t    host_req;
   logic        host_grant;
   logic        host_rvalid;
   logic [31:0] host_rdata;
   logic        dat_read;
   logic [31:0] dat_dout;
   logic        dat_empty;
   logic        dat_write;
   logic [31:0] dat_din;
   logic        dat_full;
   logic        busy;
   logic        done;
   adma_error_t adma_error;

   logic [31:0] model_mem [RAM_WORDS];  // what the host port loaded
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];
   int          value_errors;
   int          other_errors;
   int          done_total;

   clock_gen clk_gen (.CLK(CLK), .reset(reset));

   sdhc_dma_top #(.ADDR_WIDTH(ADDR_WIDTH), .FIFO_DEPTH(16)) i_dut (
      .CLK(CLK), .reset(reset),
      .reg_write(reg_write), .reg_sel(reg_sel), .reg_wdata(reg_wdata),
      .host_req(host_req), .host_grant(host_grant),
      .host_rvalid(host_rvalid), .host_rdata(host_rdata),
      .dat_read(dat_read), .dat_dout(dat_dout), .dat_empty(dat_empty),
      .dat_write(dat_write), .dat_din(dat_din), .dat_full(dat_full),
      .busy(busy), .done(done), .adma_error(adma_error)
   );

   // done and busy are stable at the falling edge
   always @(negedge CLK) begin
      if (done) begin
         done_total++;
         if (busy) begin
            $display("busy was still high in the cycle of done");
            other_errors++;
         end
      end
   end

   function automatic logic [31:0] pattern_word(input logic [31:0] key, input logic [31:0] a);
      return key + a * 32'h0001_0003;
   endfunction

   // idle cycles before a DAT port moves again, 0 means move now
   function automatic int gap_length(input int stall);
      if (($urandom % 100) < stall)
         return 1 + int'($urandom % 24);
      return 0;
   endfunction

   //////////////////////////////
   // host side
   //////////////////////////////
   task automatic mem_access(input logic wr, input logic [31:0] word_addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      int waited;
      rdata = '0;
      @(posedge CLK);
      host_req <= '{valid: 1'b1, write: wr, addr: word_addr, wdata: wdata};
      waited = 0;
      do begin
         @(posedge CLK);
         waited++;
      end while (!host_grant && waited < TIMEOUT);
      host_req <= '0;  // granted at this edge
      if (!host_grant) begin
         $display("timeout waiting for host grant at address %h", word_addr);
         other_errors++;
      end else if (!wr) begin
         waited = 0;
         do begin
            @(posedge CLK);
            waited++;
         end while (!host_rvalid && waited < TIMEOUT);
         if (host_rvalid)
            rdata = host_rdata;
         else begin
            $display("timeout waiting for host read data at address %h", word_addr);
            other_errors++;
         end
      end
   endtask

   task automatic write_reg(input reg_offset_t sel, input logic [15:0] data);
      @(posedge CLK);
      reg_write <= 1'b1;
      reg_sel   <= sel;
      reg_wdata <= data;
      @(posedge CLK);
      reg_write <= 1'b0;
   endtask

   //////////////////////////////
   // DAT side
   //////////////////////////////
   task automatic tx_drain(input int stall);
      int   issued;
      int   got;
      int   waited;
      int   gap;
      logic pending;
      issued  = 0;
      got     = 0;
      waited  = 0;
      gap     = 0;
      pending = 1'b0;
      while (got < exp_data.size() && waited < TIMEOUT) begin
         @(posedge CLK);
         waited++;
         if (pending) begin  // dout of the pop one edge back
            if (dat_dout !== exp_data[got]) begin
               $display("FAILED dat_dout word %0d: got %h, expected %h",
                        got, dat_dout, exp_data[got]);
               value_errors++;
            end
            got++;
         end
         pending = dat_read && !dat_empty;
         if (pending)
            issued++;
         if (gap > 0)
            gap--;
         else
            gap = gap_length(stall);
         dat_read <= (issued < exp_data.size()) && (gap == 0);
      end
      dat_read <= 1'b0;
      if (got < exp_data.size()) begin
         $display("timeout draining the transmit buffer, %0d of %0d words", got,
                  exp_data.size());
         other_errors++;
      end
   endtask

   task automatic rx_feed(input int stall);
      int idx;
      int waited;
      int gap;
      idx    = 0;
      waited = 0;
      gap    = 0;
      while (idx < exp_data.size() && waited < TIMEOUT) begin
         @(posedge CLK);
         waited++;
         if (dat_write && !dat_full)
            idx++;
         if (gap > 0)
            gap--;
         else
            gap = gap_length(stall);
         if (idx < exp_data.size() && gap == 0) begin
            dat_write <= 1'b1;
            dat_din   <= exp_data[idx];
         end else
            dat_write <= 1'b0;
      end
      dat_write <= 1'b0;
      if (idx < exp_data.size()) begin
         $display("timeout filling the receive buffer, %0d of %0d words", idx,
                  exp_data.size());
         other_errors++;
      end
   endtask

   task automatic background_reads(input logic [31:0] base, input int count);
      logic [31:0] a;
      logic [31:0] rdata;
      for (int i = 0; i < count; i++) begin
         a = base + i;
         mem_access(1'b0, a, 32'd0, rdata);
         if (rdata !== model_mem[a[ADDR_WIDTH-1:0]]) begin
            $display("FAILED host_rdata at %h during transfer: got %h, expected %h",
                     a, rdata, model_mem[a[ADDR_WIDTH-1:0]]);
            value_errors++;
         end
      end
   endtask

   task automatic wait_done();
      int   waited;
      logic seen;
      waited = 0;
      seen   = 1'b0;
      while (!seen && waited < TIMEOUT) begin
         @(posedge CLK);
         waited++;
         seen = done;
      end
      if (!seen) begin
         $display("timeout waiting for done");
         other_errors++;
      end
   endtask

   task automatic run_transfer(input logic [31:0] table_addr, input logic [31:0] dir,
                               input int stall, input logic [31:0] exp_err,
                               input logic [31:0] bg_base, input int bg_count);
      logic [15:0] mode_word;
      logic [31:0] rdata;
      int          done_before;
      mode_word = 16'h0000;
      mode_word[mode_dma_enable_bit] = 1'b1;
      mode_word[mode_direction_bit]  = dir[0];
      write_reg(sel_adma_addr_lo, table_addr[15:0]);
      write_reg(sel_adma_addr_hi, table_addr[31:16]);
      write_reg(sel_transfer_mode, mode_word);
      done_before = done_total;
      write_reg(sel_command, 16'h0001);
      @(negedge CLK);  // busy is up one cycle after the command write
      if (busy !== 1'b1) begin
         $display("FAILED busy after start: got %h, expected %h", busy, 1'b1);
         value_errors++;
      end
      fork
         if (dir[0])
            rx_feed(stall);
         else
            tx_drain(stall);
         background_reads(bg_base, bg_count);
         wait_done();
      join
      repeat (20) @(posedge CLK);  // window for a second done
      if (done_total - done_before != 1) begin
         $display("FAILED done count: got %h, expected %h", done_total - done_before, 1);
         value_errors++;
      end
      if (adma_error !== adma_error_t'(exp_err[1:0])) begin
         $display("FAILED adma_error: got %h, expected %h", adma_error, exp_err[1:0]);
         value_errors++;
      end
      if (!dir[0] && !dat_empty) begin
         $display("FAILED dat_empty after transfer: got %h, expected %h", dat_empty, 1'b1);
         value_errors++;
      end
      if (dir[0]) begin
         for (int i = 0; i < exp_data.size(); i++) begin
            mem_access(1'b0, exp_addr[i], 32'd0, rdata);
            if (rdata !== exp_data[i]) begin
               $display("FAILED host_rdata at %h: got %h, expected %h",
                        exp_addr[i], rdata, exp_data[i]);
               value_errors++;
            end
            model_mem[exp_addr[i][ADDR_WIDTH-1:0]] = exp_data[i];
         end
      end
      exp_addr.delete();
      exp_data.delete();
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////
   initial begin
      int                fd;
      int                code;
      int                want;
      int                waited;
      int                test_num;
      int unsigned       seed_value;
      logic [7:0]        cmd;
      logic [31:0]       a;
      logic [31:0]       b;
      logic [31:0]       c;
      logic [31:0]       d;
      logic [31:0]       e;
      logic [31:0]       f;
      logic [31:0]       rdata;
      logic [8*200-1:0]  line;
      reg_write    <= 1'b0;
      reg_sel      <= sel_adma_addr_lo;
      reg_wdata    <= 16'h0000;
      host_req     <= '0;
      dat_read     <= 1'b0;
      dat_write    <= 1'b0;
      dat_din      <= 32'h0;
      value_errors = 0;
      other_errors = 0;
      done_total   = 0;
      test_num     = 0;
      seed_value   = $urandom(32'h84317517);
      waited = 0;
      while (reset && waited < 100) begin
         @(posedge CLK);
         waited++;
      end
      if (reset) begin
         $display("timeout waiting for reset release");
         other_errors++;
      end
      fd = $fopen("testbench/sdhc_dma_testdata.txt", "r");
      if (fd == 0) begin
         $display("could not open testbench/sdhc_dma_testdata.txt");
         other_errors++;
      end else begin
         while ($fscanf(fd, " %c", cmd) == 1) begin
            want = 0;
            case (cmd)
               "#": begin
                  code = $fgets(line, fd);
                  want = code;
               end
               "F": begin  // fill a region by rule
                  code = $fscanf(fd, "%h %h %h", a, b, c);
                  want = 3;
                  for (int i = 0; i < int'(b); i++) begin
                     mem_access(1'b1, a + i, pattern_word(c, a + i), rdata);
                     model_mem[(a + i) % RAM_WORDS] = pattern_word(c, a + i);
                  end
               end
               "W": begin
                  code = $fscanf(fd, "%h %h", a, b);
                  want = 2;
                  mem_access(1'b1, a, b, rdata);
                  model_mem[a[ADDR_WIDTH-1:0]] = b;
               end
               "E": begin
                  code = $fscanf(fd, "%h %h %h", a, b, c);
                  want = 3;
                  for (int i = 0; i < int'(b); i++) begin
                     exp_addr.push_back(a + i);
                     exp_data.push_back(pattern_word(c, a + i));
                  end
               end
               "G": begin
                  code = $fscanf(fd, "%h %h %h %h %h %h", a, b, c, d, e, f);
                  want = 6;
                  test_num++;
                  $display("transfer %0d from table %h, direction %0d", test_num, a, b[0]);
                  run_transfer(a, b, int'(c), d, e, int'(f));
               end
               default: begin
                  $display("unknown command %c in the test data", cmd);
                  other_errors++;
                  code = want;
               end
            endcase
            if (code != want) begin
               $display("malformed test data record for command %c", cmd);
               other_errors++;
            end
         end
         $fclose(fd);
      end
      $display("%0d transfers, %0d value errors, %0d other errors",
               test_num, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule
